// ==== design/opPath_config.svh ====
`ifndef OPPATH_CONFIG_SVH
`define OPPATH_CONFIG_SVH

// Width of one register and of every operand on the datapath.
`define DATA_WIDTH 32

// Width of a register number. The register file holds 2**REG_ADDR_WIDTH entries.
`define REG_ADDR_WIDTH 5

// Destination register of jal.
`define LINK_REG 31

// The link value skips the delay slot, so it is the instruction PC plus eight.
`define LINK_OFFSET 8

// Width of the immediate field of an I-type word.
`define IMM_WIDTH 16

`endif

// ==== design/opPathPkg.sv ====
`default_nettype none

`include "opPath_config.svh"

package opPathPkg;

	// R-type layout of an instruction word.
	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [4:0]                 shamt;
		logic [5:0]                 funct;
	} rFormat;

	// I-type layout of the same word.
	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`IMM_WIDTH-1:0]      imm16;
	} iFormat;

	typedef union packed {
		rFormat rView;
		iFormat iView;
	} instrWord;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

	typedef enum logic [1:0] {destRt, destRd, destLink} destSelT;

	typedef enum logic {bReg, bImm} bSelT;

	typedef enum logic [1:0] {resAlu, resLink} resultSelT;

	typedef enum logic [1:0] {fwdRegFile, fwdExMem, fwdMemWb} fwdSelT;

	typedef struct packed {
		logic                       valid;
		logic [`DATA_WIDTH-1:0]     pc;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0]     rsData;
		logic [`DATA_WIDTH-1:0]     rtData;
		logic [`DATA_WIDTH-1:0]     imm32;
		aluOpT                      aluOp;
		destSelT                    destSel;
		bSelT                       bSel;
		resultSelT                  resultSel;
	} idExBundle;

	// One result on its way to the register file.
	typedef struct packed {
		logic                       valid;
		logic [`REG_ADDR_WIDTH-1:0] destReg;
		logic [`DATA_WIDTH-1:0]     data;
	} resultBundle;

	typedef struct packed {
		fwdSelT                 aSel;
		fwdSelT                 bSel;
		logic [`DATA_WIDTH-1:0] exMemData;
		logic [`DATA_WIDTH-1:0] memWbData;
	} fwdBundle;

endpackage

`default_nettype wire

// ==== design/decodeStage.sv ====
`default_nettype none

`include "opPath_config.svh"

module decodeStage
	import opPathPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instrValid,
	input  instrWord               instr,
	input  logic [`DATA_WIDTH-1:0] pc,
	input  resultBundle            wb,
	output idExBundle              idEx
);

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opOri     = 6'h0d;

	localparam logic [5:0] fnJalr = 6'h09;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	logic [`DATA_WIDTH-1:0] regFile [2**`REG_ADDR_WIDTH];
	logic [`DATA_WIDTH-1:0] rsData;
	logic [`DATA_WIDTH-1:0] rtData;
	logic [`DATA_WIDTH-1:0] imm32;
	logic                   known;
	aluOpT                  decAluOp;
	destSelT                decDest;
	bSelT                   decB;
	resultSelT              decResult;

	// Opcode zero is read through the R view, everything else through the I view.
	always_comb begin
		known = 1'b1;
		decAluOp = aluAdd;
		decDest = destRt;
		decB = bReg;
		decResult = resAlu;
		if (instr.rView.opcode == opSpecial) begin
			decDest = destRd;
			case (instr.rView.funct)
				fnAdd:   decAluOp = aluAdd;
				fnSub:   decAluOp = aluSub;
				fnAnd:   decAluOp = aluAnd;
				fnOr:    decAluOp = aluOr;
				fnSlt:   decAluOp = aluSlt;
				fnJalr:  decResult = resLink;
				default: known = 1'b0;
			endcase
		end else begin
			case (instr.iView.opcode)
				opAddi: decB = bImm;
				opOri: begin
					decB = bImm;
					decAluOp = aluOr;
				end
				opJal: begin
					decDest = destLink;
					decResult = resLink;
				end
				default: known = 1'b0;
			endcase
		end
	end

	// ori takes its immediate unsigned.
	assign imm32 = (instr.iView.opcode == opOri) ?
		{{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr.iView.imm16} :
		{{(`DATA_WIDTH-`IMM_WIDTH){instr.iView.imm16[`IMM_WIDTH-1]}}, instr.iView.imm16};

	// A register written on this edge is read as its new value.
	always_comb begin
		rsData = regFile[instr.rView.rs];
		rtData = regFile[instr.rView.rt];
		if (wb.valid && wb.destReg == instr.rView.rs) begin
			rsData = wb.data;
		end
		if (wb.valid && wb.destReg == instr.rView.rt) begin
			rtData = wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
				regFile[i] <= '0;
			end
		end else if (wb.valid) begin
			regFile[wb.destReg] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			idEx.valid <= 1'b0;
		end else begin
			idEx.valid <= instrValid && known;
		end
		idEx.pc <= pc;
		idEx.rs <= instr.rView.rs;
		idEx.rt <= instr.rView.rt;
		idEx.rd <= instr.rView.rd;
		idEx.rsData <= rsData;
		idEx.rtData <= rtData;
		idEx.imm32 <= imm32;
		idEx.aluOp <= decAluOp;
		idEx.destSel <= decDest;
		idEx.bSel <= decB;
		idEx.resultSel <= decResult;
	end

	// The execute stage drops writes to register 0, so it keeps its reset value.
	regZeroStays: assert property (@(posedge clk) disable iff (rst) regFile[0] == '0)
		else $error("register 0 holds %h", regFile[0]);

endmodule

`default_nettype wire

// ==== design/operandSelect.sv ====
`default_nettype none

`include "opPath_config.svh"

module operandSelect
	import opPathPkg::*;
(
	input  idExBundle                  idEx,
	input  fwdBundle                   fwd,
	output logic [`DATA_WIDTH-1:0]     opA,
	output logic [`DATA_WIDTH-1:0]     opB,
	output logic [`DATA_WIDTH-1:0]     storeB,
	output logic [`REG_ADDR_WIDTH-1:0] destReg
);

	// One forwarding selector, used for both source operands.
	function automatic logic [`DATA_WIDTH-1:0] pickOperand(
		input fwdSelT                 sel,
		input logic [`DATA_WIDTH-1:0] regData,
		input fwdBundle               src
	);
		case (sel)
			fwdExMem: return src.exMemData;
			fwdMemWb: return src.memWbData;
			default:  return regData;
		endcase
	endfunction

	assign opA = pickOperand(fwd.aSel, idEx.rsData, fwd);

	// The forwarded rt value, before the immediate can replace it.
	assign storeB = pickOperand(fwd.bSel, idEx.rtData, fwd);

	always_comb begin
		case (idEx.bSel)
			bImm:    opB = idEx.imm32;
			default: opB = storeB;
		endcase
	end

	always_comb begin
		case (idEx.destSel)
			destRt:  destReg = idEx.rt;
			destRd:  destReg = idEx.rd;
			default: destReg = `REG_ADDR_WIDTH'(`LINK_REG);
		endcase
	end

	// The result pipe only ever asks for one of the three sources.
	always_comb begin
		if (idEx.valid) begin
			fwdSelLegal: assert (fwd.aSel inside {fwdRegFile, fwdExMem, fwdMemWb} &&
				fwd.bSel inside {fwdRegFile, fwdExMem, fwdMemWb})
				else $error("illegal forwarding select a=%h b=%h", fwd.aSel, fwd.bSel);
		end
	end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
`default_nettype none

`include "opPath_config.svh"

module executeStage
	import opPathPkg::*;
(
	input  idExBundle   idEx,
	input  fwdBundle    fwd,
	output resultBundle exResult
);

	logic [`DATA_WIDTH-1:0]     opA;
	logic [`DATA_WIDTH-1:0]     opB;
	logic [`DATA_WIDTH-1:0]     aluOut;
	logic [`DATA_WIDTH-1:0]     linkValue;
	logic [`DATA_WIDTH-1:0]     result;
	logic [`REG_ADDR_WIDTH-1:0] destReg;
	logic                       lessThan;

	operandSelect operands (
		.idEx    (idEx),
		.fwd     (fwd),
		.opA     (opA),
		.opB     (opB),
		.storeB  (),
		.destReg (destReg)
	);

	// slt compares as two's complement.
	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (idEx.aluOp)
			aluAdd:  aluOut = opA + opB;
			aluSub:  aluOut = opA - opB;
			aluAnd:  aluOut = opA & opB;
			aluOr:   aluOut = opA | opB;
			aluSlt:  aluOut = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			default: aluOut = opA + opB;
		endcase
	end

	assign linkValue = idEx.pc + `DATA_WIDTH'(`LINK_OFFSET);

	always_comb begin
		case (idEx.resultSel)
			resLink: result = linkValue;
			default: result = aluOut;
		endcase
	end

	// A write to register 0 leaves as a bubble.
	assign exResult = '{
		valid:   idEx.valid && (destReg != '0),
		destReg: destReg,
		data:    result
	};

endmodule

`default_nettype wire

// ==== design/resultPipe.sv ====
`default_nettype none

`include "opPath_config.svh"

module resultPipe
	import opPathPkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  resultBundle exResult,
	input  idExBundle   idEx,
	output fwdBundle    fwd,
	output resultBundle wb
);

	resultBundle exMem;
	resultBundle memWb;

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem.valid <= 1'b0;
			memWb.valid <= 1'b0;
		end else begin
			exMem.valid <= exResult.valid;
			memWb.valid <= exMem.valid;
		end
		exMem.destReg <= exResult.destReg;
		exMem.data <= exResult.data;
		memWb.destReg <= exMem.destReg;
		memWb.data <= exMem.data;
	end

	// MEM/WB is also the register file write port.
	assign wb = memWb;

	// The nearer result wins. Register 0 always comes from the register file.
	function automatic fwdSelT pickSource(
		input logic [`REG_ADDR_WIDTH-1:0] src,
		input resultBundle                near,
		input resultBundle                far
	);
		if (src == '0) begin
			return fwdRegFile;
		end
		if (near.valid && near.destReg == src) begin
			return fwdExMem;
		end
		if (far.valid && far.destReg == src) begin
			return fwdMemWb;
		end
		return fwdRegFile;
	endfunction

	assign fwd = '{
		aSel:      pickSource(idEx.rs, exMem, memWb),
		bSel:      pickSource(idEx.rt, exMem, memWb),
		exMemData: exMem.data,
		memWbData: memWb.data
	};

	// The execute stage filters register 0 two cycles earlier.
	wbDestNonZero: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> wb.destReg != '0)
		else $error("write-back to register 0");

endmodule

`default_nettype wire

// ==== design/opPathTop.sv ====
`default_nettype none

`include "opPath_config.svh"

module opPathTop
	import opPathPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instrValid,
	input  instrWord               instr,
	input  logic [`DATA_WIDTH-1:0] pc,
	output resultBundle            wb
);

	idExBundle   idEx;
	resultBundle exResult;
	fwdBundle    fwd;

	// The decode stage also takes wb as its register file write port.
	decodeStage decode (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.wb         (wb),
		.idEx       (idEx)
	);

	executeStage execute (
		.idEx     (idEx),
		.fwd      (fwd),
		.exResult (exResult)
	);

	resultPipe results (
		.clk      (clk),
		.rst      (rst),
		.exResult (exResult),
		.idEx     (idEx),
		.fwd      (fwd),
		.wb       (wb)
	);

endmodule

`default_nettype wire

// ==== verification/opPathTbTable.svh ====
`ifndef OPPATH_TB_TABLE_SVH
`define OPPATH_TB_TABLE_SVH

// Columns are instruction word, PC, and a flag that allows random bubbles before the row.
// Rows without the flag keep their dependency distances fixed.
localparam int rowCount = 23;

localparam stimRow stimTable [rowCount] = '{
	// Immediates, then R-type operations at distances 3, 2 and 1.
	'{32'h20010005, 32'h00400000, 1'b1},
	'{32'h2002fffd, 32'h00400004, 1'b0},
	'{32'h34038001, 32'h00400008, 1'b0},
	'{32'h00222020, 32'h0040000c, 1'b0},
	'{32'h00812822, 32'h00400010, 1'b0},
	'{32'h00a33024, 32'h00400014, 1'b0},
	'{32'h00c23825, 32'h00400018, 1'b0},
	'{32'h00e1402a, 32'h0040001c, 1'b0},
	'{32'h0022482a, 32'h00400020, 1'b0},
	// Link instructions, with r31 used right away.
	'{32'h0c000040, 32'h00400024, 1'b1},
	'{32'h03e15020, 32'h00400028, 1'b0},
	'{32'h01405809, 32'h0040002c, 1'b0},
	// Writes to r0, a load opcode and an unknown funct, none of which write back.
	'{32'h00220020, 32'h00400030, 1'b1},
	'{32'h20001234, 32'h00400034, 1'b0},
	'{32'h8c250004, 32'h00400038, 1'b0},
	'{32'h00226018, 32'h0040003c, 1'b0},
	// r0 is read again after the writes above.
	'{32'h200c7fff, 32'h00400040, 1'b1},
	'{32'h000c6820, 32'h00400044, 1'b0},
	'{32'h35aef0f0, 32'h00400048, 1'b0},
	'{32'h21cfff00, 32'h0040004c, 1'b0},
	'{32'h01ed8022, 32'h00400050, 1'b1},
	'{32'h020e8824, 32'h00400054, 1'b1},
	'{32'h01f0902a, 32'h00400058, 1'b1}
};

`endif

// ==== verification/opPathTb.sv ====
`default_nettype none

module opPathTb
	import opPathPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [31:0] word;
		logic [31:0] pc;
		logic        gap;
	} stimRow;

`include "opPathTbTable.svh"

	logic        clk = 1'b0;
	logic        rst;
	logic        instrValid;
	instrWord    instr;
	logic [31:0] pc;
	resultBundle wb;

	logic [31:0] model [32];
	resultBundle expQ [$];
	int          dueQ [$];
	int          gaps [rowCount];
	int          edgeCount = 0;
	int          limitNs = 0;
	logic        limitReady = 1'b0;

	opPathTop UUT (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.wb         (wb)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkReg(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkWb(input resultBundle got, input resultBundle exp);
		if (got.valid !== exp.valid) begin
			failRun($sformatf("mismatch wb.valid: got %h expected %h", got.valid, exp.valid));
		end
		checkReg("wb.destReg", got.destReg, exp.destReg);
		checkData("wb.data", got.data, exp.data);
	endtask

	// MIPS semantics in program order; forwarding in the DUT must give the same values.
	task automatic modelStep(input logic [31:0] word, input logic [31:0] rowPc);
		logic [5:0]  op;
		logic [5:0]  funct;
		logic [31:0] a;
		logic [31:0] b;
		logic        writes;
		logic [4:0]  dest;
		logic [31:0] value;
		op = word[31:26];
		funct = word[5:0];
		a = model[word[25:21]];
		b = model[word[20:16]];
		writes = 1'b1;
		dest = word[15:11];
		value = '0;
		if (op == 6'h00) begin
			case (funct)
				6'h20:   value = a + b;
				6'h22:   value = a - b;
				6'h24:   value = a & b;
				6'h25:   value = a | b;
				6'h2a:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				6'h09:   value = rowPc + 32'd8;
				default: writes = 1'b0;
			endcase
		end else if (op == 6'h08) begin
			dest = word[20:16];
			value = a + {{16{word[15]}}, word[15:0]};
		end else if (op == 6'h0d) begin
			dest = word[20:16];
			value = a | {16'h0000, word[15:0]};
		end else if (op == 6'h03) begin
			dest = 5'd31;
			value = rowPc + 32'd8;
		end else begin
			writes = 1'b0;
		end
		if (writes && dest != 5'd0) begin
			model[dest] = value;
			expQ.push_back(resultBundle'{valid: 1'b1, destReg: dest, data: value});
			// Driven at this edge, sampled at the next, on wb two edges after that.
			dueQ.push_back(edgeCount + 4);
		end
	endtask

	// Every edge either has a write-back due or must show none.
	always @(negedge clk) begin
		if (!rst) begin
			if (dueQ.size() != 0 && dueQ[0] == edgeCount) begin
				checkWb(wb, expQ[0]);
				void'(expQ.pop_front());
				void'(dueQ.pop_front());
			end else if (wb.valid) begin
				failRun($sformatf("write-back to r%0d at edge %0d with nothing due",
					wb.destReg, edgeCount));
			end
		end
	end

	initial begin
		int totalGaps;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		for (int r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		void'($urandom(32'hf9589c07));
		totalGaps = 0;
		for (int i = 0; i < rowCount; i++) begin
			gaps[i] = stimTable[i].gap ? int'($urandom_range(3, 0)) : 0;
			totalGaps += gaps[i];
		end
		limitNs = (rowCount + totalGaps + 5 + 6 + 10) * 100;
		limitReady = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < rowCount; i++) begin
			repeat (gaps[i]) begin
				@(posedge clk);
				instrValid <= 1'b0;
			end
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= stimTable[i].word;
			pc <= stimTable[i].pc;
			modelStep(stimTable[i].word, stimTable[i].pc);
		end
		@(posedge clk);
		instrValid <= 1'b0;
		repeat (5) @(posedge clk);
		if (expQ.size() != 0) begin
			failRun($sformatf("%0d expected write-backs never arrived", expQ.size()));
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

	initial begin
		wait (limitReady);
		#(limitNs);
		failRun($sformatf("watchdog expired after %0d ns", limitNs));
	end

endmodule

`default_nettype wire

// ==== opPathTop.f ====
+incdir+design
+incdir+verification
design/opPathPkg.sv
design/decodeStage.sv
design/operandSelect.sv
design/executeStage.sv
design/resultPipe.sv
design/opPathTop.sv
verification/opPathTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it, and judges the run from its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module opPathTb -f opPathTop.f -o opPathSim \
	&& ./obj_dir/opPathSim 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q 'Test failures found' sim.log && { echo "FAIL"; exit 1; } || true
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
